// File: hw/alu.sv
`timescale 1ns/1ns

module alu import mips_pkg::*; (
	input logic clk,
	input logic rst_n,
	input instr_t ir,
	input logic [3:0] alu_op,
	input logic alu_src,
	input logic [31:0] rs_val,
	input logic [31:0] rt_val,
	input logic cnt_load,
	input logic shift_busy,
	input logic exec_en,
	input logic mem_en,
	input logic [31:0] mem_rdata,
	output logic [4:0] shamt_sel,
	output logic [31:0] addr,
	output logic [31:0] result
);

	logic is_shift;
	logic is_var_shift;
	logic zero_imm;
	logic [31:0] imm_ext;
	logic [31:0] op_b;
	logic [31:0] acc;
	logic [31:0] alu_val;

	assign is_shift = (ir.r.op == op_rtype) &&
		(ir.r.funct inside {fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav});
	assign is_var_shift = is_shift && (ir.r.funct inside {fn_sllv, fn_srlv, fn_srav});
	assign shamt_sel = !is_shift ? 5'd0 : (is_var_shift ? rs_val[4:0] : ir.r.shamt);

	assign zero_imm = alu_op inside {aop_and, aop_or, aop_xor}; // Logical immediates
	assign imm_ext = zero_imm ? {16'd0, ir.i.imm} : {{16{ir.i.imm[15]}}, ir.i.imm};
	assign op_b = alu_src ? imm_ext : rt_val;
	assign addr = rs_val + imm_ext;         // Loads and stores use a signed offset

	always_comb begin
		alu_val = 32'd0;
		case (alu_op)
			aop_rtype: begin
				case (ir.r.funct)
					fn_add, fn_addu: alu_val = rs_val + op_b;
					fn_sub, fn_subu: alu_val = rs_val - op_b;
					fn_and: alu_val = rs_val & op_b;
					fn_or: alu_val = rs_val | op_b;
					fn_xor: alu_val = rs_val ^ op_b;
					fn_nor: alu_val = ~(rs_val | op_b);
					fn_slt: alu_val = {31'd0, $signed(rs_val) < $signed(op_b)};
					fn_sltu: alu_val = {31'd0, rs_val < op_b};
					fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav: alu_val = acc;
					default: alu_val = 32'd0;
				endcase
			end
			aop_add, aop_addu, aop_add_sext: alu_val = rs_val + op_b;
			aop_slt: alu_val = {31'd0, $signed(rs_val) < $signed(op_b)};
			aop_sltu: alu_val = {31'd0, rs_val < op_b};
			aop_and: alu_val = rs_val & op_b;
			aop_or: alu_val = rs_val | op_b;
			aop_xor: alu_val = rs_val ^ op_b;
			aop_lui: alu_val = {ir.i.imm, 16'd0};
			default: alu_val = 32'd0;
		endcase
	end

	// Serial shifter, one position per busy cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= 32'd0;
		end else if (cnt_load) begin
			acc <= rt_val;
		end else if (exec_en && shift_busy) begin
			case (ir.r.funct)
				fn_sll, fn_sllv: acc <= {acc[30:0], 1'b0};
				fn_srl, fn_srlv: acc <= {1'b0, acc[31:1]};
				fn_sra, fn_srav: acc <= {acc[31], acc[31:1]};
				default: acc <= acc;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= 32'd0;
		end else if (mem_en) begin
			result <= mem_rdata;            // Load data replaces the address
		end else if (exec_en && !shift_busy) begin
			result <= alu_val;
		end
	end

endmodule

// File: hw/control.sv
`timescale 1ns/1ns

module control import mips_pkg::*; (
	input logic [5:0] op,
	input logic [5:0] func,
	input logic [4:0] rt_field,
	output logic [ctrl_w-1:0] control_out
);

	// Places each field at its slot in the control word
	function automatic logic [ctrl_w-1:0] pack(
		input logic [3:0] aop,
		input logic src,
		input logic [1:0] dst,
		input logic [1:0] size,
		input logic mw,
		input logic mr,
		input logic [1:0] m2r,
		input logic nl
	);
		logic [ctrl_w-1:0] w;
		w = '0;
		w[alu_op_lsb +: 4] = aop;
		w[alu_src_pos] = src;
		w[reg_dst_lsb +: 2] = dst;
		w[mem_size_lsb +: 2] = size;
		w[mem_write_pos] = mw;
		w[mem_read_pos] = mr;
		w[mem_to_reg_lsb +: 2] = m2r;
		w[no_link_pos] = nl;
		return w;
	endfunction

	always_comb begin
		control_out = '0;                   // Unknown encodings retire with no effect
		case (op)
			op_rtype: begin
				case (func)
					fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav,
					fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
					fn_xor, fn_nor, fn_slt, fn_sltu:
						control_out = pack(aop_rtype, 1'b0, 2'b01, 2'b00,
							1'b0, 1'b0, 2'b10, 1'b0);
					fn_jr: control_out = pack(aop_rtype, 1'b0, 2'b00, 2'b00,
						1'b0, 1'b0, 2'b00, 1'b1);
					fn_jalr: control_out = pack(aop_rtype, 1'b0, 2'b10, 2'b00,
						1'b0, 1'b0, 2'b00, 1'b0);
					default: control_out = '0;
				endcase
			end
			op_regimm: begin
				case (rt_field)
					rt_bgez, rt_bltz: control_out = pack(aop_add, 1'b0, 2'b00, 2'b00,
						1'b0, 1'b0, 2'b00, 1'b1);
					rt_bgezal, rt_bltzal: control_out = pack(aop_add, 1'b0, 2'b10,
						2'b00, 1'b0, 1'b0, 2'b00, 1'b0);
					default: control_out = '0;
				endcase
			end
			op_j, op_beq, op_bne, op_blez, op_bgtz:
				control_out = pack(aop_add, 1'b0, 2'b00, 2'b00, 1'b0, 1'b0, 2'b00, 1'b1);
			op_jal: control_out = pack(aop_add, 1'b0, 2'b10, 2'b00, 1'b0, 1'b0, 2'b00, 1'b0);
			op_rfe, op_trap: control_out = '0;  // Exceptions are outside this core

			// Immediate arithmetic writes rt from the ALU
			op_addi: control_out = pack(aop_add, 1'b1, 2'b00, 2'b00, 1'b0, 1'b0, 2'b10, 1'b0);
			op_addiu: control_out = pack(aop_addu, 1'b1, 2'b00, 2'b00, 1'b0, 1'b0, 2'b10, 1'b0);
			op_slti: control_out = pack(aop_slt, 1'b1, 2'b00, 2'b00, 1'b0, 1'b0, 2'b10, 1'b0);
			op_sltiu: control_out = pack(aop_sltu, 1'b1, 2'b00, 2'b00, 1'b0, 1'b0, 2'b10, 1'b0);
			op_andi: control_out = pack(aop_and, 1'b1, 2'b00, 2'b00, 1'b0, 1'b0, 2'b10, 1'b0);
			op_ori: control_out = pack(aop_or, 1'b1, 2'b00, 2'b00, 1'b0, 1'b0, 2'b10, 1'b0);
			op_xori: control_out = pack(aop_xor, 1'b1, 2'b00, 2'b00, 1'b0, 1'b0, 2'b10, 1'b0);
			op_lui: control_out = pack(aop_lui, 1'b1, 2'b00, 2'b00, 1'b0, 1'b0, 2'b10, 1'b0);

			// Loads, sign extension rides on the ALU op
			op_lb: control_out = pack(aop_add_sext, 1'b1, 2'b00, 2'b10, 1'b0, 1'b1, 2'b01, 1'b0);
			op_lbu: control_out = pack(aop_add, 1'b1, 2'b00, 2'b10, 1'b0, 1'b1, 2'b01, 1'b0);
			op_lh: control_out = pack(aop_add_sext, 1'b1, 2'b00, 2'b01, 1'b0, 1'b1, 2'b01, 1'b0);
			op_lhu: control_out = pack(aop_add, 1'b1, 2'b00, 2'b01, 1'b0, 1'b1, 2'b01, 1'b0);
			op_lw: control_out = pack(aop_add, 1'b1, 2'b00, 2'b00, 1'b0, 1'b1, 2'b01, 1'b0);

			op_sb: control_out = pack(aop_add, 1'b1, 2'b00, 2'b10, 1'b1, 1'b0, 2'b00, 1'b1);
			op_sh: control_out = pack(aop_add, 1'b1, 2'b00, 2'b01, 1'b1, 1'b0, 2'b00, 1'b1);
			op_sw: control_out = pack(aop_add, 1'b1, 2'b00, 2'b00, 1'b1, 1'b0, 2'b00, 1'b1);
			default: control_out = '0;
		endcase
	end

endmodule

// File: hw/data_mem.sv
`timescale 1ns/1ns

module data_mem import mips_pkg::*; (
	input logic clk,
	input logic [31:0] addr,
	input logic we,
	input logic [1:0] mem_size,
	input logic sign_ext,
	input logic [31:0] wdata,
	output logic [31:0] rdata
);

	localparam int aw = $clog2(mem_words);

	logic [31:0] mem [mem_words];
	logic [aw-1:0] idx;
	logic [31:0] word;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;

	initial begin
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = 32'd0;                 // Memory starts cleared
		end
	end

	assign idx = addr[aw+1:2];              // Upper address bits wrap
	assign word = mem[idx];
	assign byte_sel = word[8*addr[1:0] +: 8];  // Little-endian lanes
	assign half_sel = word[16*addr[1] +: 16];

	always_ff @(posedge clk) begin
		if (we) begin
			case (mem_size)
				2'b10: mem[idx][8*addr[1:0] +: 8] <= wdata[7:0];
				2'b01: mem[idx][16*addr[1] +: 16] <= wdata[15:0];
				default: mem[idx] <= wdata;
			endcase
		end
	end

	always_comb begin
		case (mem_size)
			2'b10: rdata = {{24{sign_ext & byte_sel[7]}}, byte_sel};
			2'b01: rdata = {{16{sign_ext & half_sel[15]}}, half_sel};
			default: rdata = word;
		endcase
	end

endmodule

// File: hw/exec_fsm.sv
`timescale 1ns/1ns

module exec_fsm import mips_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input logic mem_read,
	input logic mem_write,
	input logic [1:0] mem_to_reg,
	input logic shift_busy,
	output logic ready,
	output logic instr_load,
	output logic cnt_load,
	output logic exec_en,
	output logic mem_en,
	output logic wb_en,
	output logic done
);

	logic [2:0] state;
	logic [2:0] state_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (instr_valid) begin
					state_nxt = st_decode;      // Accept edge
				end
			end
			st_decode: state_nxt = st_exec;     // Counter and shift register load here
			st_exec: begin
				if (shift_busy) begin
					state_nxt = st_exec;        // One shift step per cycle
				end else if (mem_read || mem_write) begin
					state_nxt = st_mem;
				end else begin
					state_nxt = st_wb;
				end
			end
			st_mem: state_nxt = st_wb;
			st_wb: state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobes decoded from the state
	assign ready = (state == st_idle);
	assign instr_load = ready && instr_valid;  // Requests outside IDLE are dropped
	assign cnt_load = (state == st_decode);
	assign exec_en = (state == st_exec);
	assign mem_en = (state == st_mem);
	assign wb_en = (state == st_wb) && (mem_to_reg != 2'b00); // Only when a result exists
	assign done = (state == st_wb);

endmodule

// File: hw/mips_exec_top.sv
`timescale 1ns/1ns

module mips_exec_top import mips_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input logic [31:0] instr,
	output logic ready,
	output logic done,
	output logic wb_valid,
	output logic [4:0] wb_addr,
	output logic [31:0] wb_data
);

	instr_t ir;
	logic [ctrl_w-1:0] ctrl;
	logic [3:0] alu_op;
	logic alu_src, mem_write, mem_read;
	logic [1:0] reg_dst, mem_size, mem_to_reg;
	logic instr_load, cnt_load, exec_en, mem_en, wb_en, shift_busy;
	logic [4:0] shamt_sel, dest;
	logic [31:0] rs_val, rt_val, addr, mem_rdata, result;

	always_ff @(posedge clk) begin
		if (instr_load) begin
			ir <= instr;                    // Held until the next accept
		end
	end

	control u_control (.op(ir.r.op), .func(ir.r.funct), .rt_field(ir.i.rt),
		.control_out(ctrl));

	assign alu_op = ctrl[alu_op_lsb +: 4];
	assign alu_src = ctrl[alu_src_pos];
	assign reg_dst = ctrl[reg_dst_lsb +: 2];
	assign mem_size = ctrl[mem_size_lsb +: 2];
	assign mem_write = ctrl[mem_write_pos];
	assign mem_read = ctrl[mem_read_pos];
	assign mem_to_reg = ctrl[mem_to_reg_lsb +: 2];

	always_comb begin
		case (reg_dst)
			2'b01: dest = ir.r.rd;
			2'b10: dest = 5'd31;            // Link register
			default: dest = ir.r.rt;
		endcase
	end

	assign wb_valid = wb_en && (dest != 5'd0);
	assign wb_addr = dest;
	assign wb_data = result;

	exec_fsm u_fsm (.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid),
		.mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
		.shift_busy(shift_busy), .ready(ready), .instr_load(instr_load),
		.cnt_load(cnt_load), .exec_en(exec_en), .mem_en(mem_en), .wb_en(wb_en), .done(done));

	shift_counter u_shift_cnt (.clk(clk), .rst_n(rst_n), .cnt_load(cnt_load),
		.cnt_en(exec_en), .amount(shamt_sel), .busy(shift_busy));

	alu u_alu (.clk(clk), .rst_n(rst_n), .ir(ir), .alu_op(alu_op), .alu_src(alu_src),
		.rs_val(rs_val), .rt_val(rt_val), .cnt_load(cnt_load), .shift_busy(shift_busy),
		.exec_en(exec_en), .mem_en(mem_en), .mem_rdata(mem_rdata),
		.shamt_sel(shamt_sel), .addr(addr), .result(result));

	reg_file u_regs (.clk(clk), .rst_n(rst_n), .ra(ir.r.rs), .rb(ir.r.rt),
		.we(wb_valid), .wa(dest), .wd(result), .qa(rs_val), .qb(rt_val));

	data_mem u_dmem (.clk(clk), .addr(addr), .we(mem_en && mem_write), .mem_size(mem_size),
		.sign_ext(alu_op == aop_add_sext), .wdata(rt_val), .rdata(mem_rdata));

endmodule

// File: hw/mips_pkg.sv
package mips_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcode, funct and rt-field encodings
	localparam logic [5:0] op_rtype = 6'b000000, op_regimm = 6'b000001, op_j = 6'b000010;
	localparam logic [5:0] op_jal = 6'b000011, op_beq = 6'b000100, op_bne = 6'b000101;
	localparam logic [5:0] op_blez = 6'b000110, op_bgtz = 6'b000111, op_addi = 6'b001000;
	localparam logic [5:0] op_addiu = 6'b001001, op_slti = 6'b001010, op_sltiu = 6'b001011;
	localparam logic [5:0] op_andi = 6'b001100, op_ori = 6'b001101, op_xori = 6'b001110;
	localparam logic [5:0] op_lui = 6'b001111, op_rfe = 6'b010000, op_trap = 6'b010001;
	localparam logic [5:0] op_lb = 6'b100000, op_lh = 6'b100001, op_lw = 6'b100011;
	localparam logic [5:0] op_lbu = 6'b100100, op_lhu = 6'b100101, op_sb = 6'b101000;
	localparam logic [5:0] op_sh = 6'b101001, op_sw = 6'b101011;

	localparam logic [5:0] fn_sll = 6'b000000, fn_srl = 6'b000010, fn_sra = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100, fn_srlv = 6'b000110, fn_srav = 6'b000111;
	localparam logic [5:0] fn_jr = 6'b001000, fn_jalr = 6'b001001, fn_add = 6'b100000;
	localparam logic [5:0] fn_addu = 6'b100001, fn_sub = 6'b100010, fn_subu = 6'b100011;
	localparam logic [5:0] fn_and = 6'b100100, fn_or = 6'b100101, fn_xor = 6'b100110;
	localparam logic [5:0] fn_nor = 6'b100111, fn_slt = 6'b101010, fn_sltu = 6'b101011;

	localparam logic [4:0] rt_bgez = 5'b00001, rt_bgezal = 5'b10001;
	localparam logic [4:0] rt_bltzal = 5'b10000, rt_bltz = 5'b00000;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control word layout, msb first
	localparam int ctrl_w = 14;
	localparam int alu_op_lsb = 10;            // 4 bits
	localparam int alu_src_pos = 9;            // Immediate as second operand
	localparam int reg_dst_lsb = 7;            // 2 bits, rt / rd / link
	localparam int mem_size_lsb = 5;           // 2 bits, word / half / byte
	localparam int mem_write_pos = 4;
	localparam int mem_read_pos = 3;
	localparam int mem_to_reg_lsb = 1;         // 2 bits, none / memory / ALU
	localparam int no_link_pos = 0;

	localparam logic [3:0] aop_rtype = 4'd0;   // Operation comes from funct
	localparam logic [3:0] aop_add = 4'd1;
	localparam logic [3:0] aop_addu = 4'd2;
	localparam logic [3:0] aop_slt = 4'd3;
	localparam logic [3:0] aop_sltu = 4'd4;
	localparam logic [3:0] aop_and = 4'd5;
	localparam logic [3:0] aop_or = 4'd6;
	localparam logic [3:0] aop_xor = 4'd7;
	localparam logic [3:0] aop_lui = 4'd8;
	localparam logic [3:0] aop_add_sext = 4'd9; // Address add for signed loads

	localparam int mem_words = 64;

	// Sequencer states
	localparam logic [2:0] st_idle = 3'd0, st_decode = 3'd1, st_exec = 3'd2;
	localparam logic [2:0] st_mem = 3'd3, st_wb = 3'd4;

	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
	} instr_t;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input logic clk,
	input logic rst_n,
	input logic [4:0] ra,
	input logic [4:0] rb,
	input logic we,
	input logic [4:0] wa,
	input logic [31:0] wd,
	output logic [31:0] qa,
	output logic [31:0] qb
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;                 // r0 is never written
		end
	end

	// Asynchronous read ports
	assign qa = (ra == 5'd0) ? 32'd0 : regs[ra];
	assign qb = (rb == 5'd0) ? 32'd0 : regs[rb];

endmodule

// File: hw/shift_counter.sv
`timescale 1ns/1ns

module shift_counter (
	input logic clk,
	input logic rst_n,
	input logic cnt_load,
	input logic cnt_en,
	input logic [4:0] amount,
	output logic busy
);

	logic [4:0] count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= 5'd0;
		end else if (cnt_load) begin
			count <= amount;                // Zero amount means no shift cycles
		end else if (cnt_en && (count != 5'd0)) begin
			count <= count - 5'd1;
		end
	end

	// Steps still owed to the shift register
	assign busy = (count != 5'd0);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module tb_mips_exec -o Vtb_mips_exec

./obj_dir/Vtb_mips_exec 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi
echo "Simulation passed"

// File: tests/mips_model.svh
// Architectural state as the instruction set defines it
logic [31:0] ref_regs [32];
logic [31:0] ref_mem [mem_words];

task automatic clear_model();
	for (int i = 0; i < 32; i++) begin
		ref_regs[i] = 32'd0;
	end
	for (int i = 0; i < mem_words; i++) begin
		ref_mem[i] = 32'd0;
	end
endtask

// Executes one instruction and returns the register write it causes, if any
task automatic predict(input logic [31:0] word, output logic wr, output logic [4:0] dst,
	output logic [31:0] val, output int shamt);
	instr_t d;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] ea;
	logic [31:0] w;
	int sh8;
	int sh16;
	d = word;
	a = ref_regs[d.r.rs];
	b = ref_regs[d.r.rt];
	simm = {{16{d.i.imm[15]}}, d.i.imm};
	ea = a + simm;
	w = ref_mem[ea[7:2]];                  // Upper address bits wrap
	sh8 = 8 * ea[1:0];
	sh16 = 16 * ea[1];
	dst = d.i.rt;
	val = 32'd0;
	shamt = -1;
	wr = (d.i.op inside {op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori,
		op_lui, op_lb, op_lbu, op_lh, op_lhu, op_lw});
	case (d.i.op)
		op_rtype: begin
			wr = 1'b1;
			dst = d.r.rd;
			case (d.r.funct)
				fn_sll: val = b << d.r.shamt;
				fn_srl: val = b >> d.r.shamt;
				fn_sra: val = $signed(b) >>> d.r.shamt;
				fn_sllv: val = b << a[4:0];
				fn_srlv: val = b >> a[4:0];
				fn_srav: val = $signed(b) >>> a[4:0];
				fn_add, fn_addu: val = a + b;
				fn_sub, fn_subu: val = a - b;
				fn_and: val = a & b;
				fn_or: val = a | b;
				fn_xor: val = a ^ b;
				fn_nor: val = ~(a | b);
				fn_slt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				fn_sltu: val = (a < b) ? 32'd1 : 32'd0;
				default: wr = 1'b0;        // jr, jalr and unknown functs
			endcase
			if (d.r.funct inside {fn_sll, fn_srl, fn_sra}) begin
				shamt = d.r.shamt;
			end else if (d.r.funct inside {fn_sllv, fn_srlv, fn_srav}) begin
				shamt = a[4:0];
			end
		end
		op_addi, op_addiu: val = a + simm;
		op_slti: val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
		op_sltiu: val = (a < simm) ? 32'd1 : 32'd0;
		op_andi: val = a & {16'd0, d.i.imm};
		op_ori: val = a | {16'd0, d.i.imm};
		op_xori: val = a ^ {16'd0, d.i.imm};
		op_lui: val = {d.i.imm, 16'd0};
		op_lb: val = {{24{w[sh8 + 7]}}, 8'(w >> sh8)};
		op_lbu: val = {24'd0, 8'(w >> sh8)};
		op_lh: val = {{16{w[sh16 + 15]}}, 16'(w >> sh16)};
		op_lhu: val = {16'd0, 16'(w >> sh16)};
		op_lw: val = w;
		op_sb: ref_mem[ea[7:2]] = (w & ~(32'hff << sh8)) | ({24'd0, b[7:0]} << sh8);
		op_sh: ref_mem[ea[7:2]] = (w & ~(32'hffff << sh16)) | ({16'd0, b[15:0]} << sh16);
		op_sw: ref_mem[ea[7:2]] = b;
		default: val = 32'd0;              // Branches, jumps and undefined codes
	endcase
	if (dst == 5'd0) begin
		wr = 1'b0;
	end
	if (wr) begin
		ref_regs[dst] = val;
	end
endtask

// File: tests/tb_mips_exec.sv
`timescale 1ns/1ns

module tb_mips_exec import mips_pkg::*; ();

	logic clk;
	logic rst_n;
	logic instr_valid;
	logic [31:0] instr;
	logic ready;
	logic done;
	logic wb_valid;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;
	int seed;
	int shift_lat [32];                    // Last latency seen for each shift amount

	logic [5:0] funct_tbl [19] = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav,
		fn_jr, fn_jalr, fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
		fn_slt, fn_sltu, 6'b111111};
	logic [5:0] mem_tbl [8] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw};
	logic [5:0] flow_tbl [9] = '{op_regimm, op_j, op_jal, op_beq, op_bne, op_blez, op_bgtz,
		op_rfe, op_trap};
	logic [4:0] rt_tbl [4] = '{rt_bgez, rt_bgezal, rt_bltzal, rt_bltz};

	`include "mips_model.svh"

	mips_exec_top UUT (.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.ready(ready), .done(done), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
			name, got, exp));
	endtask

	task automatic expect_true(input bit cond, input string why);
		assert (cond) else fail_run(why);
	endtask

	// Register indices stay below 8 so results get reused
	function automatic logic [31:0] random_instr();
		instr_t w;
		int kind;
		w = $random(seed);
		w.i.rs = {2'b00, w.i.rs[2:0]};
		w.i.rt = {2'b00, w.i.rt[2:0]};
		kind = {$random(seed)} % 10;
		if (kind < 3) begin
			w.r.op = op_rtype;
			w.r.rd = {2'b00, w.r.rd[2:0]};
			w.r.funct = funct_tbl[{$random(seed)} % 19];
		end else if (kind < 6) begin
			w.i.op = op_addi + 6'({$random(seed)} % 8);   // addi through lui
		end else if (kind < 8) begin
			w.i.op = mem_tbl[{$random(seed)} % 8];
			w.i.rs = 5'd0;                  // Absolute address inside the memory
			w.i.imm = {8'd0, w.i.imm[7:0]};
		end else if (kind == 8) begin
			w.i.op = flow_tbl[{$random(seed)} % 9];
			if (w.i.op == op_regimm) begin
				w.i.rt = rt_tbl[{$random(seed)} % 4];
			end
		end else begin
			w.i.op = 6'b110000 + 6'({$random(seed)} % 8);  // Unassigned opcodes
		end
		return w;
	endfunction

	task automatic check_shift_order(input int amt, input int lat);
		for (int b = 0; b < 32; b++) begin
			if (shift_lat[b] >= 0 && b != amt) begin
				expect_true((b < amt) ? (shift_lat[b] < lat) : (shift_lat[b] > lat),
					"A larger shift amount did not finish later than a smaller one");
			end
		end
		shift_lat[amt] = lat;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One instruction from accept to done, optionally with ignored strobes in between
	task automatic issue(input logic [31:0] word, input bit noise);
		logic exp_wr;
		logic [4:0] exp_dst;
		logic [31:0] exp_val;
		int amt;
		int cycles;
		compare_value("ready", {31'd0, ready}, 32'd1);
		instr = word;
		instr_valid = 1'b1;
		predict(word, exp_wr, exp_dst, exp_val, amt);
		@(negedge clk);
		instr_valid = 1'b0;
		compare_value("ready", {31'd0, ready}, 32'd0);   // Dropped after the accept edge
		cycles = 1;
		while (done !== 1'b1) begin
			expect_true(cycles < 100, "Timeout: done never came within 100 cycles");
			compare_value("wb_valid", {31'd0, wb_valid}, 32'd0);  // Writeback only with done
			if (noise) begin
				instr_valid = 1'($random(seed));
				instr = $random(seed);
			end
			@(negedge clk);
			cycles++;
		end
		instr_valid = 1'b0;
		compare_value("wb_valid", {31'd0, wb_valid}, {31'd0, exp_wr});
		if (exp_wr) begin
			compare_value("wb_addr", {27'd0, wb_addr}, {27'd0, exp_dst});
			compare_value("wb_data", wb_data, exp_val);
		end
		if (amt >= 0) begin
			check_shift_order(amt, cycles);
		end
		@(negedge clk);
		compare_value("done", {31'd0, done}, 32'd0);     // A single cycle pulse
	endtask

	task automatic read_registers();
		for (int r = 1; r < 32; r++) begin
			issue({op_rtype, 5'(r), 5'd0, 5'(r), 5'd0, fn_addu}, 1'b0);  // addu rX, rX, r0
		end
	endtask

	task automatic read_memory();
		for (int i = 0; i < mem_words; i++) begin
			issue({op_lw, 5'd0, 5'd1, 16'(i * 4)}, 1'b0);
		end
	endtask

	initial begin
		seed = 32'h5f70;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = 32'd0;
		for (int i = 0; i < 32; i++) begin
			shift_lat[i] = -1;
		end
		clear_model();
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		compare_value("ready", {31'd0, ready}, 32'd1);
		compare_value("done", {31'd0, done}, 32'd0);
		compare_value("wb_valid", {31'd0, wb_valid}, 32'd0);
		read_registers();
		repeat (2000) issue(random_instr(), 1'b1);
		read_registers();                   // Final state must still match the model
		read_memory();
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: verilog.f
hw/mips_pkg.sv
hw/control.sv
hw/exec_fsm.sv
hw/shift_counter.sv
hw/reg_file.sv
hw/alu.sv
hw/data_mem.sv
hw/mips_exec_top.sv
+incdir+tests
tests/tb_mips_exec.sv
